/* mcoi_display.f */
hdl/mcoi_display_pkg.sv
hdl/heartbeat_blinker.sv
hdl/led_pattern_regs.sv
hdl/tlc5920_driver.sv
hdl/mcoi_display_system.sv
testbench/tlc5920_model.sv
testbench/tb_mcoi_display.sv

/* testbench/tb_mcoi_display.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mcoi_display
   import mcoi_display_pkg::*;
();

   localparam int c_blink_count = 40;
   localparam int c_ack_timeout = 20;

   logic        clk_tree_x;
   logic        rst_n;
   logic        cyc;
   logic        stb;
   logic        we;
   logic [3:0]  adr;
   logic [15:0] dat_w;
   wire  [15:0] dat_r;
   wire         ack;
   wire         sclk;
   wire         sin;
   wire         latch;
   wire         blank;
   wire  [1:0]  csel;
   wire         led_heartbeat;
   wire         led_display_on;
   wire  [c_rows-1:0][c_row_bits-1:0] image;
   wire  [31:0] latch_count;

   int          err_cnt = 0;
   int          test_err_base = 0;
   int          pass_tests = 0;
   int          fail_tests = 0;
   integer      seed;
   logic [15:0] shadow [8];
   logic        in_window;
   logic        latch_q;
   logic [1:0]  next_csel;

   mcoi_display_system #(
      .g_divider     (1),
      .g_blink_count (c_blink_count)
   ) DUT (
      .clk_tree_x (clk_tree_x), .rst_n (rst_n), .cyc (cyc), .stb (stb), .we (we),
      .adr (adr), .dat_w (dat_w), .dat_r (dat_r), .ack (ack), .sclk (sclk), .sin (sin),
      .latch (latch), .blank (blank), .csel (csel), .led_heartbeat (led_heartbeat),
      .led_display_on (led_display_on)
   );

   tlc5920_model model_i (
      .clk_tree_x (clk_tree_x), .rst_n (rst_n), .sclk (sclk), .sin (sin),
      .latch (latch), .csel (csel), .image (image), .latch_count (latch_count)
   );

   always #10 clk_tree_x = ~clk_tree_x;

   // ------------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------------
   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
         err_cnt++;
      end
   endtask

   // scan outputs quiet while in reset
   a_reset_quiet : assert property (@(posedge clk_tree_x)
      !rst_n |-> blank && !latch && !sclk && !sin && !ack)
   else begin
      $display("FAILED at %0t ns: {blank,latch,sclk,sin,ack} expected 10000, got %b",
               $time, $sampled({blank, latch, sclk, sin, ack}));
      err_cnt++;
   end

   a_ack_one_clock : assert property (@(posedge clk_tree_x) disable iff (!rst_n)
      ack |=> !ack)
   else begin
      $display("FAILED at %0t ns: ack expected 0, got 1 (second clock)", $time);
      err_cnt++;
   end

   // display off means a dark and idle panel
   a_window_dark : assert property (@(posedge clk_tree_x) disable iff (!rst_n)
      in_window |-> blank && !latch && !sclk)
   else begin
      $display("FAILED at %0t ns: {blank,latch,sclk} expected 100, got %b",
               $time, $sampled({blank, latch, sclk}));
      err_cnt++;
   end

   // rows latched in order 0,1,2,3
   always @(posedge clk_tree_x or negedge rst_n) begin
      if (!rst_n) begin
         latch_q   <= 1'b0;
         next_csel <= 2'd0;
      end else begin
         latch_q <= latch;
         if (latch && !latch_q) begin
            check_value("csel", next_csel, csel);
            next_csel <= next_csel + 2'd1;
         end
      end
   end

   // reset frame has rows 0 and 2 full in state 1 and rows 1 and 3 alternating
   function automatic logic [15:0] pattern_word(input int w);
      logic [15:0] s1;
      logic [15:0] s0;
      s1 = ((w / 2) % 2 == 0) ? 16'hFFFF : 16'hAAAA;
      s0 = ((w / 2) % 2 == 0) ? 16'hAAAA : 16'h0000;
      return (w % 2 == 1) ? s1 : s0;
   endfunction

   // ------------------------------------------------------------------------
   // wishbone master and wait helpers
   // ------------------------------------------------------------------------
   task automatic bus_transfer(input logic write, input logic [3:0] a,
                               input logic [15:0] wdata, output logic [15:0] rdata);
      int waited;
      waited = 0;
      rdata  = '0;
      @(posedge clk_tree_x);
      #2;
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = write;
      adr   = a;
      dat_w = wdata;
      do begin
         @(negedge clk_tree_x);
         waited++;
      end while (!ack && waited < c_ack_timeout);
      if (!ack) begin
         $display("TIMEOUT: no ack for address %0d within %0d clocks", a, c_ack_timeout);
         err_cnt++;
      end else begin
         rdata = dat_r;
      end
      @(posedge clk_tree_x);
      #2;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
      // one clock of ack only
      @(negedge clk_tree_x);
      check_value("ack", 1'b0, ack);
   endtask

   task automatic wait_latches(input int n, input int timeout);
      logic [31:0] target;
      int          waited;
      target = latch_count + n;
      waited = 0;
      while (latch_count < target && waited < timeout) begin
         @(negedge clk_tree_x);
         waited++;
      end
      if (latch_count < target) begin
         $display("TIMEOUT: %0d latch events not seen within %0d clocks", n, timeout);
         err_cnt++;
      end
   endtask

   // blank high without latch only once the driver sits in idle
   task automatic wait_display_idle();
      int waited;
      waited = 0;
      while (!(blank && !latch) && waited < 1000) begin
         @(negedge clk_tree_x);
         waited++;
      end
      if (!(blank && !latch)) begin
         $display("TIMEOUT: driver did not go idle within 1000 clocks");
         err_cnt++;
      end
   endtask

   task automatic measure_toggle(output int clocks);
      logic start;
      start  = led_heartbeat;
      clocks = 0;
      do begin
         @(negedge clk_tree_x);
         clocks++;
      end while (led_heartbeat == start && clocks < 200);
      if (led_heartbeat == start) begin
         $display("TIMEOUT: led_heartbeat did not toggle within 200 clocks");
         err_cnt++;
      end
   endtask

   task automatic finish_test(input string name);
      if (err_cnt == test_err_base) begin
         pass_tests++;
         $display("test %s: ok", name);
      end else begin
         fail_tests++;
         $display("test %s: %0d errors", name, err_cnt - test_err_base);
      end
      test_err_base = err_cnt;
   endtask

   // ------------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------------
   initial begin
      logic [15:0] rd;
      logic [31:0] mark;
      int          clocks;
      clk_tree_x = 1'b0;
      rst_n      = 1'b1;
      cyc        = 1'b0;
      stb        = 1'b0;
      we         = 1'b0;
      adr        = '0;
      dat_w      = '0;
      in_window  = 1'b0;
      seed       = 66324;
      // reset falls after time zero so every flop sees the edge
      #2;
      rst_n = 1'b0;
      repeat (16) @(posedge clk_tree_x);
      #2;
      rst_n = 1'b1;

      // reset values hold until the first tick
      @(negedge clk_tree_x);
      check_value("blank", 1'b1, blank);
      check_value("latch", 1'b0, latch);
      check_value("sclk", 1'b0, sclk);
      check_value("sin", 1'b0, sin);
      check_value("ack", 1'b0, ack);
      for (int w = 0; w < 8; w++) begin
         bus_transfer(1'b0, 4'(w), 16'h0, rd);
         check_value($sformatf("dat_r word %0d", w), pattern_word(w), rd);
         shadow[w] = pattern_word(w);
      end
      bus_transfer(1'b0, 4'd8, 16'h0, rd);
      check_value("dat_r ctrl", 16'h0001, rd);
      finish_test("reset_state");

      for (int w = 0; w < 8; w++) begin
         shadow[w] = 16'($random(seed));
         bus_transfer(1'b1, 4'(w), shadow[w], rd);
      end
      for (int w = 0; w < 8; w++) begin
         bus_transfer(1'b0, 4'(w), 16'h0, rd);
         check_value($sformatf("dat_r word %0d", w), shadow[w], rd);
      end
      finish_test("register_access");

      // address 12 is outside the map
      bus_transfer(1'b1, 4'd12, 16'($random(seed)), rd);
      bus_transfer(1'b0, 4'd12, 16'h0, rd);
      check_value("dat_r addr 12", 16'h0000, rd);
      for (int w = 0; w < 8; w++) begin
         bus_transfer(1'b0, 4'(w), 16'h0, rd);
         check_value($sformatf("dat_r word %0d", w), shadow[w], rd);
      end
      finish_test("unmapped_address");

      for (int w = 0; w < 8; w++) begin
         shadow[w] = 16'($random(seed));
         bus_transfer(1'b1, 4'(w), shadow[w], rd);
      end
      wait_latches(8, 4000);
      for (int r = 0; r < c_rows; r++) begin
         check_value($sformatf("image row %0d", r), {shadow[2*r+1], shadow[2*r]}, image[r]);
      end
      finish_test("display_content");

      bus_transfer(1'b1, 4'd8, 16'h0000, rd);
      check_value("led_display_on", 1'b0, led_display_on);
      wait_display_idle();
      mark = latch_count;
      @(posedge clk_tree_x);
      #2;
      in_window = 1'b1;
      repeat (500) @(posedge clk_tree_x);
      #2;
      in_window = 1'b0;
      check_value("latch_count", mark, latch_count);
      bus_transfer(1'b1, 4'd8, 16'h0001, rd);
      check_value("led_display_on", 1'b1, led_display_on);
      wait_latches(1, 1000);
      finish_test("display_disable");

      // first call only aligns to a toggle
      measure_toggle(clocks);
      repeat (3) begin
         measure_toggle(clocks);
         check_value("led_heartbeat period", c_blink_count + 1, clocks);
      end
      finish_test("heartbeat");

      $display("tests passed: %0d, tests failed: %0d, errors: %0d",
               pass_tests, fail_tests, err_cnt);
      if (err_cnt == 0 && fail_tests == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/tlc5920_model.sv */
`timescale 1ns/10ps
`default_nettype none

module tlc5920_model
   import mcoi_display_pkg::*;
(
   input  wire                               clk_tree_x,
   input  wire                               rst_n,
   input  wire                               sclk,
   input  wire                               sin,
   input  wire                               latch,
   input  wire  [1:0]                        csel,
   // one image per row, {state 1, state 0}
   output logic [c_rows-1:0][c_row_bits-1:0] image,
   output logic [31:0]                       latch_count
);

   logic [c_row_bits-1:0] shift_q;
   logic                  sclk_q;
   logic                  latch_q;

   // pins sampled on the system clock, edges found against the last sample
   always @(posedge clk_tree_x or negedge rst_n) begin
      if (!rst_n) begin
         shift_q     <= '0;
         sclk_q      <= 1'b0;
         latch_q     <= 1'b0;
         image       <= '0;
         latch_count <= '0;
      end else begin
         sclk_q  <= sclk;
         latch_q <= latch;
         // sin taken on rising sclk, first bit ends at the msb
         if (sclk && !sclk_q) begin
            shift_q <= {shift_q[c_row_bits-2:0], sin};
         end
         // latch copies the shift register into the selected row
         if (latch && !latch_q) begin
            image[csel] <= shift_q;
            latch_count <= latch_count + 1;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/mcoi_display_system.sv */
`timescale 1ns/10ps
`default_nettype none

module mcoi_display_system
   import mcoi_display_pkg::*;
#(
   // tlc5920 tick divider, 10 mhz scan from 100 mhz
   parameter int g_divider     = 9,
   // heartbeat half period minus one, in clocks
   parameter int g_blink_count = 10000000
) (
   input  wire               clk_tree_x,
   input  wire               rst_n,
   // wishbone classic slave
   input  wire               cyc,
   input  wire               stb,
   input  wire               we,
   input  wire  [3:0]        adr,
   input  wire  [c_cols-1:0] dat_w,
   output logic [c_cols-1:0] dat_r,
   output logic              ack,
   // tlc5920 bar led chip
   output logic              sclk,
   output logic              sin,
   output logic              latch,
   output logic              blank,
   output logic [1:0]        csel,
   // diagnostic leds
   output logic              led_heartbeat,
   output logic              led_display_on
);

   // frame buffer as seen by the driver
   logic [c_rows*c_row_bits-1:0] frame;
   logic                         display_en;

   // ------------------------------------------------------------------------
   // clock alive indicator
   // ------------------------------------------------------------------------
   heartbeat_blinker #(
      .g_blink_count (g_blink_count)
   ) heartbeat_blinker_i (
      .clk_tree_x    (clk_tree_x),
      .rst_n         (rst_n),
      .led_heartbeat (led_heartbeat)
   );

   // frame buffer and control, wishbone side
   led_pattern_regs led_pattern_regs_i (
      .clk_tree_x (clk_tree_x),
      .rst_n      (rst_n),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .dat_w      (dat_w),
      .dat_r      (dat_r),
      .ack        (ack),
      .frame      (frame),
      .display_en (display_en)
   );

   // ------------------------------------------------------------------------
   // row scan towards the led bar
   // ------------------------------------------------------------------------
   tlc5920_driver #(
      .g_divider (g_divider)
   ) tlc5920_driver_i (
      .clk_tree_x (clk_tree_x),
      .rst_n      (rst_n),
      .frame      (frame),
      .display_en (display_en),
      .sclk       (sclk),
      .sin        (sin),
      .latch      (latch),
      .blank      (blank),
      .csel       (csel)
   );

   // enable bit mirrored on the panel
   assign led_display_on = display_en;

endmodule

`default_nettype wire

/* hdl/tlc5920_driver.sv */
`timescale 1ns/10ps
`default_nettype none

module tlc5920_driver
   import mcoi_display_pkg::*;
#(
   parameter int g_divider = 9
) (
   input  wire                           clk_tree_x,
   input  wire                           rst_n,
   // frame words and enable from the register block
   input  wire  [c_rows*c_row_bits-1:0]  frame,
   input  wire                           display_en,
   // tlc5920 pins
   output logic                          sclk,
   output logic                          sin,
   output logic                          latch,
   output logic                          blank,
   output logic [1:0]                    csel
);

   // +2 keeps at least one bit for tiny dividers
   localparam int c_div_w      = $clog2(g_divider + 2);
   localparam int c_bit_w      = $clog2(c_row_bits + 1);
   localparam int c_show_ticks = 16;

   logic [c_div_w-1:0]               div_cnt;
   logic                             tick;
   scan_state_t                      state;
   logic [c_row_bits-1:0]            shreg;
   logic [c_bit_w-1:0]               bit_cnt;
   logic [$clog2(c_show_ticks)-1:0]  show_cnt;
   logic [1:0]                       row_q;
   logic [1:0]                       load_row;
   logic [c_row_bits-1:0]            row_bits;
   logic                             show_done;
   logic                             do_load;
   logic                             do_shift;

   // ------------------------------------------------------------------------
   // tick divider, one clock in g_divider+1
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_tree_x or negedge rst_n) begin
      if (!rst_n) begin
         div_cnt <= '0;
      end else if (tick) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   assign tick = (div_cnt == c_div_w'(g_divider));

   // ------------------------------------------------------------------------
   // row data selection
   // ------------------------------------------------------------------------
   // end of show already points at the following row
   assign load_row  = (state == st_show) ? row_q + 2'd1 : row_q;
   // {state 1, state 0} of the row, msb goes out first
   assign row_bits  = frame[load_row*c_row_bits +: c_row_bits];
   assign show_done = (show_cnt == '1);

   assign do_load  = tick && display_en &&
                     ((state == st_idle) || (state == st_show && show_done));
   // next bit onto sin on the falling sclk tick
   assign do_shift = tick && (state == st_shift) && sclk &&
                     (bit_cnt != c_bit_w'(c_row_bits));

   // remaining bits of the row, first bit already on sin
   always_ff @(posedge clk_tree_x) begin
      if (do_load) begin
         shreg <= {row_bits[c_row_bits-2:0], 1'b0};
      end else if (do_shift) begin
         shreg <= {shreg[c_row_bits-2:0], 1'b0};
      end
   end

   // ------------------------------------------------------------------------
   // scan fsm
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_tree_x or negedge rst_n) begin
      if (!rst_n) begin
         state    <= st_idle;
         sclk     <= 1'b0;
         sin      <= 1'b0;
         latch    <= 1'b0;
         blank    <= 1'b1;
         csel     <= '0;
         row_q    <= '0;
         bit_cnt  <= '0;
         show_cnt <= '0;
      end else if (tick) begin
         case (state)
            st_idle: begin
               // blanked, poll the enable each tick
               if (display_en) begin
                  sin     <= row_bits[c_row_bits-1];
                  bit_cnt <= '0;
                  state   <= st_shift;
               end
            end
            st_shift: begin
               if (!sclk) begin
                  // rising edge, chip samples sin
                  sclk    <= 1'b1;
                  bit_cnt <= bit_cnt + 1'b1;
               end else begin
                  sclk <= 1'b0;
                  if (bit_cnt == c_bit_w'(c_row_bits)) begin
                     // all 32 bits in, latch and blank together
                     sin   <= 1'b0;
                     latch <= 1'b1;
                     blank <= 1'b1;
                     csel  <= row_q;
                     state <= st_latch;
                  end else begin
                     sin <= shreg[c_row_bits-1];
                  end
               end
            end
            st_latch: begin
               // unblank the freshly latched row
               latch    <= 1'b0;
               blank    <= 1'b0;
               show_cnt <= '0;
               state    <= st_show;
            end
            st_show: begin
               if (show_done) begin
                  row_q <= row_q + 2'd1;
                  if (display_en) begin
                     sin     <= row_bits[c_row_bits-1];
                     bit_cnt <= '0;
                     state   <= st_shift;
                  end else begin
                     blank <= 1'b1;
                     state <= st_idle;
                  end
               end else begin
                  show_cnt <= show_cnt + 1'b1;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // latch pulse never overlaps a shift clock
   a_latch_no_sclk : assert property (
      @(posedge clk_tree_x) disable iff (!rst_n)
      latch |-> !sclk
   );

   // outputs stay dark while the latch updates
   a_latch_blanked : assert property (
      @(posedge clk_tree_x) disable iff (!rst_n)
      latch |-> blank
   );

endmodule

`default_nettype wire

/* hdl/led_pattern_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module led_pattern_regs
   import mcoi_display_pkg::*;
(
   input  wire                               clk_tree_x,
   input  wire                               rst_n,
   // wishbone classic slave
   input  wire                               cyc,
   input  wire                               stb,
   input  wire                               we,
   input  wire  [3:0]                        adr,
   input  wire  [c_cols-1:0]                 dat_w,
   output logic [c_cols-1:0]                 dat_r,
   output logic                              ack,
   // towards the scan driver
   output logic [c_rows*c_row_bits-1:0]      frame,
   output logic                              display_en
);

   // eight frame words, word index = row*2 + state
   logic [c_rows*c_states-1:0][c_cols-1:0] frame_q;
   reg_addr_t                              addr_dec;
   logic                                   xfer;
   logic                                   wr_en;
   logic [c_cols-1:0]                      rd_data;

   assign addr_dec = reg_addr_t'(adr);

   // new request only while ack is low, gives single cycle ack
   assign xfer  = cyc & stb & ~ack;
   assign wr_en = xfer & we;

   assign frame = frame_q;

   // ------------------------------------------------------------------------
   // handshake and register writes
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_tree_x or negedge rst_n) begin
      if (!rst_n) begin
         ack        <= 1'b0;
         frame_q    <= c_test_pattern;
         display_en <= 1'b1;
      end else begin
         ack <= xfer;
         if (wr_en) begin
            case (addr_dec)
               addr_row0_s0, addr_row0_s1,
               addr_row1_s0, addr_row1_s1,
               addr_row2_s0, addr_row2_s1,
               addr_row3_s0, addr_row3_s1: frame_q[adr[2:0]] <= dat_w;
               // only bit 0 is implemented
               addr_ctrl: display_en <= dat_w[0];
               // unmapped, write dropped
               default: ;
            endcase
         end
      end
   end

   // ------------------------------------------------------------------------
   // read mux
   // ------------------------------------------------------------------------
   always_comb begin
      rd_data = '0;
      case (addr_dec)
         addr_row0_s0, addr_row0_s1,
         addr_row1_s0, addr_row1_s1,
         addr_row2_s0, addr_row2_s1,
         addr_row3_s0, addr_row3_s1: rd_data = frame_q[adr[2:0]];
         addr_ctrl: rd_data = {{(c_cols-1){1'b0}}, display_en};
         // unmapped reads as zero
         default: rd_data = '0;
      endcase
   end

   // captured with the request, valid together with ack
   always_ff @(posedge clk_tree_x) begin
      if (xfer) begin
         dat_r <= rd_data;
      end
   end

   // ack answers a request seen on the previous clock
   a_ack_follows_req : assert property (
      @(posedge clk_tree_x) disable iff (!rst_n)
      ack |-> $past(cyc && stb)
   );

   // ack lasts exactly one clock
   a_ack_single : assert property (
      @(posedge clk_tree_x) disable iff (!rst_n)
      ack |=> !ack
   );

endmodule

`default_nettype wire

/* hdl/heartbeat_blinker.sv */
`timescale 1ns/10ps
`default_nettype none

module heartbeat_blinker #(
   parameter int g_blink_count = 10000000
) (
   input  wire  clk_tree_x,
   input  wire  rst_n,
   output logic led_heartbeat
);

   // wide enough to hold the terminal count
   localparam int c_cnt_w = $clog2(g_blink_count + 1);

   logic [c_cnt_w-1:0] cnt;
   logic               terminal;

   assign terminal = (cnt == c_cnt_w'(g_blink_count));

   // period of g_blink_count+1 clocks per toggle
   always_ff @(posedge clk_tree_x or negedge rst_n) begin
      if (!rst_n) begin
         cnt           <= '0;
         led_heartbeat <= 1'b0;
      end else if (terminal) begin
         // wrap and flip the led
         cnt           <= '0;
         led_heartbeat <= ~led_heartbeat;
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   // counter must wrap at terminal count, never run past it
   a_cnt_range : assert property (
      @(posedge clk_tree_x) disable iff (!rst_n)
      cnt <= c_cnt_w'(g_blink_count)
   );

endmodule

`default_nettype wire

/* hdl/mcoi_display_pkg.sv */
`default_nettype none

package mcoi_display_pkg;

   // ------------------------------------------------------------------------
   // front panel geometry
   // ------------------------------------------------------------------------
   localparam int c_rows     = 4;
   localparam int c_states   = 2;
   // also the wishbone data width
   localparam int c_cols     = 16;
   localparam int c_row_bits = c_states * c_cols;

   // built-in test pattern, [row][state][column]
   // word w = row*2 + state sits at bits 16w and up when flattened
   localparam logic [c_rows-1:0][c_states-1:0][c_cols-1:0] c_test_pattern = {
      16'hAAAA, 16'h0000,   // row 3: s1, s0
      16'hFFFF, 16'hAAAA,   // row 2
      16'hAAAA, 16'h0000,   // row 1
      16'hFFFF, 16'hAAAA    // row 0
   };

   // scan fsm of the tlc5920 driver
   typedef enum logic [1:0] {st_idle, st_shift, st_latch, st_show} scan_state_t;

   // register word map, unlisted codes are unmapped
   typedef enum logic [3:0] {
      addr_row0_s0 = 4'd0, addr_row0_s1 = 4'd1,
      addr_row1_s0 = 4'd2, addr_row1_s1 = 4'd3,
      addr_row2_s0 = 4'd4, addr_row2_s1 = 4'd5,
      addr_row3_s0 = 4'd6, addr_row3_s1 = 4'd7,
      addr_ctrl    = 4'd8
   } reg_addr_t;

endpackage

`default_nettype wire
